/* rtl/lar_cfg.svh */
`ifndef LAR_CFG_SVH
`define LAR_CFG_SVH

// one line of the LAR file, in bits
`define LAR_LINE_WIDTH 256

// lines in the LAR file
`define LAR_NUM_LINES 4

// wishbone data width, also the widest scalar
`define SCALAR_WIDTH 64

// used address bits: line, data type, int size, byte offset
`define LAR_ADR_WIDTH 11

`endif

/* rtl/lar_pkg.sv */
`default_nettype none

`include "lar_cfg.svh"

package lar_pkg;

	typedef logic [`LAR_LINE_WIDTH-1:0] lar_line_t;
	typedef logic [`SCALAR_WIDTH-1:0] scalar_t;
	typedef logic [$clog2(`LAR_NUM_LINES)-1:0] line_idx_t;
	typedef logic [$clog2(`LAR_LINE_WIDTH/8)-1:0] data_offset_t;
	// bit position of an element inside a line
	typedef logic [$clog2(`LAR_LINE_WIDTH)-1:0] bit_pos_t;

	typedef logic [1:0] data_type_t;
	localparam data_type_t data_type_unsgn = 2'd0;
	localparam data_type_t data_type_sgn = 2'd1;
	localparam data_type_t data_type_bfloat16 = 2'd2;
	localparam data_type_t data_type_reserved = 2'd3;

	typedef logic [1:0] int_size_t;
	localparam int_size_t int_size_8 = 2'd0;
	localparam int_size_t int_size_16 = 2'd1;
	localparam int_size_t int_size_32 = 2'd2;
	localparam int_size_t int_size_64 = 2'd3;

	typedef enum logic [1:0] {
		idle,
		issue,
		wait_ack
	} decode_state_t;

	// address field positions
	localparam int unsigned adr_offset_lsb = 0;
	localparam int unsigned adr_size_lsb = 5;
	localparam int unsigned adr_type_lsb = 7;
	localparam int unsigned adr_line_lsb = 9;

	// bfloat16 always behaves as a 16-bit element
	function automatic int_size_t elem_size(data_type_t data_type, int_size_t int_size);
		return (data_type == data_type_bfloat16) ? int_size_16 : int_size;
	endfunction

	function automatic scalar_t elem_mask(int_size_t size);
		case (size)
			int_size_8: return scalar_t'(8'hff);
			int_size_16: return scalar_t'(16'hffff);
			int_size_32: return scalar_t'(32'hffff_ffff);
			default: return '1;
		endcase
	endfunction

	// byte offset aligned down to the element size, turned into a bit position
	function automatic bit_pos_t elem_bit_pos(data_offset_t offset, int_size_t size);
		data_offset_t aligned;
		aligned = offset & ~data_offset_t'((1 << size) - 1);
		return bit_pos_t'(aligned) << 3;
	endfunction

endpackage

`default_nettype wire

/* rtl/lar_access_if.sv */
`default_nettype none

// one decoded access, decode to execute
interface lar_access_if
	import lar_pkg::*;
();

	logic valid;
	logic we;
	line_idx_t line;
	data_type_t data_type;
	int_size_t int_size;
	data_offset_t offset;
	scalar_t wdata;
	// data type field held the reserved code
	logic reserved;

	modport decode
	(
		output valid, we, line, data_type, int_size, offset, wdata, reserved
	);

	modport execute
	(
		input valid, we, line, data_type, int_size, offset, wdata, reserved
	);

endinterface

`default_nettype wire

/* rtl/lar_access_decode.sv */
`default_nettype none

`include "lar_cfg.svh"

module lar_access_decode
	import lar_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [`LAR_ADR_WIDTH-1:0] adr,
	input wire scalar_t dat_w,
	input wire logic ack,
	lar_access_if.decode access
);

	decode_state_t state;
	logic take;

	// only one access in flight
	assign take = (state == idle) && cyc && stb;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= idle;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (take)
						state <= issue;
				end
				issue:
					state <= wait_ack;
				// request still high in the ack cycle is not taken again
				wait_ack:
				begin
					if (ack)
						state <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

	// split the address into its fields
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			access.we <= we;
			access.wdata <= dat_w;
			access.offset <= adr[adr_offset_lsb +: $bits(data_offset_t)];
			access.int_size <= adr[adr_size_lsb +: $bits(int_size_t)];
			access.data_type <= adr[adr_type_lsb +: $bits(data_type_t)];
			access.line <= adr[adr_line_lsb +: $bits(line_idx_t)];
		end
	end

	assign access.valid = (state == issue);
	assign access.reserved = (access.data_type == data_type_reserved);

endmodule

`default_nettype wire

/* rtl/scalar_data_shifter.sv */
`default_nettype none

// no casting here, elements are only moved and zero-extended
module scalar_shift_read
	import lar_pkg::*;
(
	input wire lar_line_t line_data,
	input wire data_type_t data_type,
	input wire int_size_t int_size,
	input wire data_offset_t offset,
	output scalar_t data
);

	int_size_t size;
	bit_pos_t bit_pos;
	scalar_t window;

	always_comb
	begin
		size = elem_size(data_type, int_size);
		bit_pos = elem_bit_pos(offset, size);
		// element lands in the low bits
		window = scalar_t'(line_data >> bit_pos);

		if (data_type == data_type_reserved)
			data = '0;
		else
			data = window & elem_mask(size);
	end

endmodule

module scalar_shift_write
	import lar_pkg::*;
(
	input wire lar_line_t to_modify,
	input wire scalar_t to_shift,
	input wire data_type_t data_type,
	input wire int_size_t int_size,
	input wire data_offset_t offset,
	output lar_line_t data
);

	int_size_t size;
	bit_pos_t bit_pos;
	lar_line_t clear_mask;
	lar_line_t insert;

	always_comb
	begin
		size = elem_size(data_type, int_size);
		bit_pos = elem_bit_pos(offset, size);
		clear_mask = lar_line_t'(elem_mask(size)) << bit_pos;
		// upper bits of the write data are dropped
		insert = lar_line_t'(to_shift & elem_mask(size)) << bit_pos;

		// reserved type leaves the line as it was
		if (data_type == data_type_reserved)
			data = to_modify;
		else
			data = (to_modify & ~clear_mask) | insert;
	end

endmodule

`default_nettype wire

/* rtl/lar_access_execute.sv */
`default_nettype none

`include "lar_cfg.svh"

module lar_access_execute
	import lar_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	lar_access_if.execute access,
	output logic rd_valid,
	output scalar_t rd_data
);

	lar_line_t lines [`LAR_NUM_LINES];
	lar_line_t sel_line;
	lar_line_t merged;
	scalar_t extracted;

	// both shifters see the addressed line
	assign sel_line = lines[access.line];

	scalar_shift_read u_shift_read
	(
		.line_data(sel_line),
		.data_type(access.data_type),
		.int_size(access.int_size),
		.offset(access.offset),
		.data(extracted)
	);

	scalar_shift_write u_shift_write
	(
		.to_modify(sel_line),
		.to_shift(access.wdata),
		.data_type(access.data_type),
		.int_size(access.int_size),
		.offset(access.offset),
		.data(merged)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `LAR_NUM_LINES; i++)
				lines[i] <= '0;
			rd_valid <= 1'b0;
			rd_data <= '0;
		end
		else
		begin
			// pulses for writes too, so every access gets its ack
			rd_valid <= access.valid;

			if (access.valid && access.we && !access.reserved)
				lines[access.line] <= merged;

			if (access.valid && !access.we)
				rd_data <= extracted;
		end
	end

endmodule

`default_nettype wire

/* rtl/lar_access_result.sv */
`default_nettype none

module lar_access_result
	import lar_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic rd_valid,
	input wire scalar_t rd_data,
	output logic ack,
	output scalar_t dat_r
);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ack <= 1'b0;
			dat_r <= '0;
		end
		else
		begin
			// rd_valid is a single pulse, so ack is too
			ack <= rd_valid;

			// dat_r holds until the next access completes
			if (rd_valid)
				dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/lar_scalar_port.sv */
`default_nettype none

`include "lar_cfg.svh"

module lar_scalar_port
	import lar_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [`LAR_ADR_WIDTH-1:0] adr,
	input wire scalar_t dat_w,
	output wire scalar_t dat_r,
	output wire logic ack
);

	lar_access_if access();

	wire logic rd_valid;
	wire scalar_t rd_data;

	lar_access_decode u_decode
	(
		.clk(clk),
		.arst_n(arst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.ack(ack),
		.access(access.decode)
	);

	lar_access_execute u_execute
	(
		.clk(clk),
		.arst_n(arst_n),
		.access(access.execute),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	lar_access_result u_result
	(
		.clk(clk),
		.arst_n(arst_n),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.ack(ack),
		.dat_r(dat_r)
	);

endmodule

`default_nettype wire

/* verification/lar_scalar_port_props.sv */
`default_nettype none

module lar_scalar_port_props
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack
);

	timeunit 1ns;
	timeprecision 100ps;

	logic busy;
	logic accepted;

	// mirrors the single outstanding access of the slave
	assign accepted = cyc && stb && !busy;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			busy <= 1'b0;
		else if (accepted)
			busy <= 1'b1;
		else if (ack)
			busy <= 1'b0;
	end

	ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
		else $error("ack stayed high for two cycles");

	ack_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> cyc && stb && busy)
		else $error("ack without an outstanding request");

	ack_on_third_edge: assert property (@(posedge clk) disable iff (!arst_n)
		$past(accepted, 3) |-> ack)
		else $error("ack missing three edges after an accepted request");

	ack_rise_timed: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(accepted, 3))
		else $error("ack rose at the wrong edge");

	ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
		else $error("ack high during reset");

endmodule

bind lar_scalar_port lar_scalar_port_props u_props
(
	.clk(clk),
	.arst_n(arst_n),
	.cyc(cyc),
	.stb(stb),
	.ack(ack)
);

`default_nettype wire

/* verification/lar_scalar_port_tb.sv */
`default_nettype none

`include "lar_cfg.svh"

module lar_scalar_port_tb
	import lar_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_random = 40;
	localparam int n_bf16 = 12;
	localparam int n_reserved = 8;
	// request edge plus three edges to ack plus the drop edge
	localparam int access_cycles = 5;
	localparam int reset_cycles = 8;
	localparam int n_accesses = 16 + 2 * n_random + 2 * n_bf16 + 3 * n_reserved + 9;
	localparam int cycle_limit = n_accesses * access_cycles + reset_cycles + 50;
	localparam int ack_limit = 8;

	logic clk = 1'b0;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [`LAR_ADR_WIDTH-1:0] adr;
	scalar_t dat_w;
	scalar_t dat_r;
	logic ack;

	lar_line_t model_lines [4];
	logic [15:0] lfsr = 16'd83;
	int cycle_count = 0;
	int checks = 0;
	int failures = 0;
	int ack_failures = 0;

	always #10 clk = ~clk;

	lar_scalar_port u_lar_scalar_port
	(
		.clk(clk),
		.arst_n(arst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout, the run needed more than %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// galois lfsr stepped once per bit
	function automatic logic [63:0] random_bits(int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			value = {value[62:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic int element_width(data_type_t dtype, int_size_t size);
		if (dtype == data_type_bfloat16)
			return 16;
		return 8 << size;
	endfunction

	// lsb of the element the offset falls in
	function automatic int aligned_lsb(data_type_t dtype, int_size_t size, data_offset_t offset);
		int bytes;
		bytes = element_width(dtype, size) / 8;
		return (int'(offset) / bytes) * bytes * 8;
	endfunction

	function automatic scalar_t expected_read(line_idx_t line, data_type_t dtype,
		int_size_t size, data_offset_t offset);
		scalar_t value;
		int lsb;
		value = '0;
		lsb = aligned_lsb(dtype, size, offset);
		if (dtype != data_type_reserved)
			for (int b = 0; b < element_width(dtype, size); b++)
				value[b] = model_lines[line][lsb + b];
		return value;
	endfunction

	task automatic apply_write(line_idx_t line, data_type_t dtype, int_size_t size,
		data_offset_t offset, scalar_t value);
		int lsb;
		lsb = aligned_lsb(dtype, size, offset);
		if (dtype != data_type_reserved)
			for (int b = 0; b < element_width(dtype, size); b++)
				model_lines[line][lsb + b] = value[b];
	endtask

	task automatic check_value(scalar_t got, scalar_t expected, string what);
		checks++;
		if (got !== expected)
		begin
			failures++;
			$display("[ERROR] %0d ns: %s, got %h, expected %h",
				$time, what, got, expected);
		end
	endtask

	// one classic cycle with stb dropped on the edge after ack
	task automatic wb_access(logic write, line_idx_t line, data_type_t dtype, int_size_t size,
		data_offset_t offset, scalar_t wdata, output scalar_t rdata);
		int edges;
		int mark;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= {line, dtype, size, offset};
		dat_w <= wdata;
		edges = 0;
		mark = failures;
		do
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		while (!ack && edges < ack_limit);
		rdata = dat_r;
		if (!ack)
		begin
			checks++;
			failures++;
			$display("ack never came within %0d cycles for an access to line %0d",
				ack_limit, line);
		end
		else
			check_value(scalar_t'(edges), 64'd3, "ack latency in edges");
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		@(negedge clk);
		check_value(scalar_t'(ack), 64'd0, "ack high for a second cycle");
		ack_failures += failures - mark;
	endtask

	task automatic write_value(line_idx_t line, data_type_t dtype, int_size_t size,
		data_offset_t offset, scalar_t value);
		scalar_t ignored;
		wb_access(1'b1, line, dtype, size, offset, value, ignored);
		apply_write(line, dtype, size, offset, value);
	endtask

	task automatic read_check(line_idx_t line, data_type_t dtype, int_size_t size,
		data_offset_t offset, string what);
		scalar_t got;
		wb_access(1'b0, line, dtype, size, offset, 64'd0, got);
		check_value(got, expected_read(line, dtype, size, offset), what);
	endtask

	task automatic report_test(string name, int failed);
		if (failed == 0)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d mismatches", name, failed);
	endtask

	initial
	begin
		int mark;
		data_type_t dtype;
		line_idx_t line;
		data_offset_t offset;
		int_size_t size;

		arst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		for (int l = 0; l < 4; l++)
			model_lines[l] = '0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);

		mark = failures;
		check_value(scalar_t'(ack), 64'd0, "ack before any request");
		for (int l = 0; l < 4; l++)
			for (int o = 0; o < 32; o += 8)
				read_check(line_idx_t'(l), data_type_unsgn, int_size_64, data_offset_t'(o),
					"read after reset");
		report_test("reset contents", failures - mark);

		// integer types read back through the other signedness
		mark = failures;
		repeat (n_random)
		begin
			line = line_idx_t'(random_bits(2));
			dtype = data_type_t'(random_bits(1));
			size = int_size_t'(random_bits(2));
			offset = data_offset_t'(random_bits(5));
			write_value(line, dtype, size, offset, random_bits(64));
			offset = (offset & 5'h18) | data_offset_t'(random_bits(3));
			read_check(line, dtype ^ 2'd1, size, offset, "integer read");
		end
		report_test("random integer access", failures - mark);

		mark = failures;
		repeat (n_bf16)
		begin
			line = line_idx_t'(random_bits(2));
			offset = data_offset_t'(random_bits(5));
			write_value(line, data_type_bfloat16, int_size_t'(random_bits(2)), offset,
				random_bits(64));
			read_check(line, data_type_bfloat16, int_size_t'(random_bits(2)), offset,
				"bfloat16 read");
		end
		report_test("bfloat16 access", failures - mark);

		mark = failures;
		repeat (n_reserved)
		begin
			line = line_idx_t'(random_bits(2));
			offset = data_offset_t'(random_bits(5));
			write_value(line, data_type_reserved, int_size_t'(random_bits(2)), offset,
				random_bits(64));
			read_check(line, data_type_reserved, int_size_t'(random_bits(2)), offset,
				"reserved read");
			read_check(line, data_type_unsgn, int_size_64, offset, "line after reserved write");
		end
		report_test("reserved type", failures - mark);

		// known fill and then one byte changed
		mark = failures;
		line = line_idx_t'(random_bits(2));
		for (int q = 0; q < 4; q++)
			write_value(line, data_type_unsgn, int_size_64, data_offset_t'(q * 8),
				64'h0123_4567_89ab_cdef ^ scalar_t'(q));
		write_value(line, data_type_unsgn, int_size_8, data_offset_t'(random_bits(5)),
			random_bits(64));
		for (int q = 0; q < 4; q++)
			read_check(line, data_type_unsgn, int_size_64, data_offset_t'(q * 8),
				"neighbour bytes");
		report_test("neighbour preservation", failures - mark);

		report_test("ack timing", ack_failures);
		$display("checks passed %0d, failed %0d", checks - failures, failures);
		if (failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/lar_pkg.sv
rtl/lar_access_if.sv
rtl/lar_access_decode.sv
rtl/scalar_data_shifter.sv
rtl/lar_access_execute.sv
rtl/lar_access_result.sv
rtl/lar_scalar_port.sv
verification/lar_scalar_port_props.sv
verification/lar_scalar_port_tb.sv

/* Makefile */
TOP = lar_scalar_port_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
